//--- bench/mem_checker.sv
`timescale 1ns/1ps

module mem_checker (
    input logic                clk,
    input logic                valid_out,
    input mem_pkg::data_t      op_val    [mem_pkg::NUM_OPS],
    input mem_pkg::addr_t      dest_addr [mem_pkg::NUM_OPS],
    input mem_pkg::dest_type_t dest_type [mem_pkg::NUM_OPS],
    input logic                ie_out,
    input mem_pkg::ie_type_t   ie_type_out
);

    typedef struct packed {
        mem_pkg::data_t      [mem_pkg::NUM_OPS-1:0] ops;
        mem_pkg::addr_t      [mem_pkg::NUM_OPS-1:0] daddr;
        mem_pkg::dest_type_t [mem_pkg::NUM_OPS-1:0] dtype;
        logic                                       ie;
        mem_pkg::ie_type_t                          ie_type;
        logic [31:0]                                stamp;
    } beat_t;

    beat_t expected_q [$];
    int    cycle       = 0;
    int    error_count = 0;
    int    beat_count  = 0;

    // called by the testbench at the acceptance edge
    task automatic push_expected(
        input mem_pkg::data_t      [mem_pkg::NUM_OPS-1:0] ops,
        input mem_pkg::addr_t      [mem_pkg::NUM_OPS-1:0] daddr,
        input mem_pkg::dest_type_t [mem_pkg::NUM_OPS-1:0] dtype,
        input logic                                       ie,
        input mem_pkg::ie_type_t                          ie_type
    );
        expected_q.push_back('{ops, daddr, dtype, ie, ie_type, cycle});
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input beat_t b);
        beat_count++;
        if (b.stamp + 1 != cycle) begin
            error_count++;
            $display("beat accepted at cycle %0d came out at cycle %0d, not the next one",
                     b.stamp, cycle);
        end
        for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
            compare_value($sformatf("op_val[%0d]", i), b.ops[i], op_val[i]);
            compare_value($sformatf("dest_addr[%0d]", i), b.daddr[i], dest_addr[i]);
            compare_value($sformatf("dest_type[%0d]", i), 32'(b.dtype[i]), 32'(dest_type[i]));
        end
        compare_value("ie_out", 32'(b.ie), 32'(ie_out));
        compare_value("ie_type_out", 32'(b.ie_type), 32'(ie_type_out));
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (valid_out) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("valid_out at cycle %0d with no accepted instruction behind it", cycle);
            end else begin
                check_beat(expected_q.pop_front());
            end
        end else if (expected_q.size() > 0 && expected_q[0].stamp + 1 == cycle) begin
            error_count++;
            $display("instruction accepted at cycle %0d never appeared on valid_out",
                     expected_q[0].stamp);
            void'(expected_q.pop_front());
        end
    end

endmodule

//--- bench/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions #(
    parameter int EX_CREDITS = 4
) (
    input logic                                clk,
    input logic                                arst_n,
    input logic                                stall,
    input logic                                valid_out,
    input logic [$clog2(EX_CREDITS + 1)-1:0]   credit_cnt
);

    int fail_count = 0;

    // free slots in the execute buffer never exceed its depth
    count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= EX_CREDITS)
    else begin
        fail_count++;
        $error("credit count above the execute buffer depth");
    end

    // a stalled cycle accepts nothing, so no beat follows it
    no_accept_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> !valid_out)
    else begin
        fail_count++;
        $error("instruction accepted while stall was high");
    end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !valid_out)
    else begin
        fail_count++;
        $error("valid_out high in the first cycle after reset");
    end

endmodule

bind mem_stage_reg mem_stage_assertions #(.EX_CREDITS(EX_CREDITS)) assert_i (
    .clk(clk),
    .arst_n(arst_n),
    .stall(stall),
    .valid_out(valid_out),
    .credit_cnt(credit_cnt)
);

//--- bench/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top;

    localparam int TLB_ENTRIES = 8;
    localparam int EX_CREDITS  = 4;
    localparam int N           = mem_pkg::NUM_OPS;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int MODE_OPS    = 0;
    localparam int MODE_DEST   = 1;
    localparam int MODE_TLB    = 2;
    localparam int MODE_SEG    = 3;
    // random instructions, two TLB fills and the credit test
    localparam int STIM_CYCLES = 300 + 3 * 200 + 2 * TLB_ENTRIES + 3 * EX_CREDITS;
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                tlb_wr_en;
    logic [IDX_W-1:0]    tlb_wr_idx;
    mem_pkg::vpn_t       tlb_wr_vpn;
    mem_pkg::pfn_t       tlb_wr_pfn;
    logic                tlb_wr_writable;
    mem_pkg::data_t      reg_data [N];
    mem_pkg::seg_t       seg_data [N];
    mem_pkg::data_t      mem_data;
    mem_pkg::addr_t      eip;
    mem_pkg::imm_t       imm;
    mem_pkg::addr_t      mem_addr;
    logic                mem_write;
    logic                mem_access;
    mem_pkg::sel_t       op_sel   [N];
    mem_pkg::sel_t       dest_sel [N];
    logic                valid_in;
    logic                ie_in;
    mem_pkg::ie_type_t   ie_type_in;
    mem_pkg::addr_t      mem_addr_end;
    mem_pkg::addr_t      seg_limit;
    logic                credit_return;
    logic                stall;
    logic                valid_out;
    mem_pkg::data_t      op_val    [N];
    mem_pkg::addr_t      dest_addr [N];
    mem_pkg::dest_type_t dest_type [N];
    logic                ie_out;
    mem_pkg::ie_type_t   ie_type_out;

    // reference TLB built from the writes driven into the DUT
    logic                m_valid    [TLB_ENTRIES];
    logic                m_writable [TLB_ENTRIES];
    mem_pkg::vpn_t       m_vpn      [TLB_ENTRIES];
    mem_pkg::pfn_t       m_pfn      [TLB_ENTRIES];
    mem_pkg::vpn_t       page_pool  [TLB_ENTRIES];

    logic [31:0] lfsr_state = 32'h9730_4a89;
    int          held = 0;
    logic        returns_on = 1'b1;
    logic        return_pending = 1'b0;
    logic        accepted_now = 1'b0;
    int          cycle_count = 0;
    int          tb_fails = 0;
    int          test_num = 1;

    mem_top #(.TLB_ENTRIES(TLB_ENTRIES), .EX_CREDITS(EX_CREDITS)) dut_i (.*);

    mem_checker checker_i (.clk, .valid_out, .op_val, .dest_addr, .dest_type,
                           .ie_out, .ie_type_out);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic int total_errors();
        return checker_i.error_count + tb_fails + dut_i.stage_i.assert_i.fail_count;
    endfunction

    function automatic mem_pkg::data_t model_operand(input mem_pkg::sel_t sel);
        logic [1:0] idx;
        idx = sel[1:0];
        case (sel[3:2])
            mem_pkg::SEL_KIND_REG: return reg_data[idx];
            mem_pkg::SEL_KIND_SEG: return {16'h0000, seg_data[idx]};
            mem_pkg::SEL_KIND_MEM: return mem_data;
            default: begin
                if (idx == mem_pkg::SPECIAL_EIP) return eip;
                if (idx == mem_pkg::SPECIAL_IMM_LO) return imm[31:0];
                if (idx == mem_pkg::SPECIAL_IMM_HI) return imm[63:32];
                return 32'h0;
            end
        endcase
    endfunction

    task automatic push_model();
        mem_pkg::data_t      [N-1:0] ops;
        mem_pkg::addr_t      [N-1:0] daddr;
        mem_pkg::dest_type_t [N-1:0] dtype;
        mem_pkg::addr_t              phys;
        mem_pkg::ie_type_t           ie_type;
        logic                        hit;
        logic                        prot;
        logic                        seg_prot;
        hit  = 1'b0;
        prot = 1'b0;
        phys = mem_addr;
        // first matching entry from index 0 translates
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (mem_access && !hit && m_valid[i] && m_vpn[i] == mem_addr[31:12]) begin
                hit  = 1'b1;
                prot = mem_write && !m_writable[i];
                phys = {m_pfn[i], mem_addr[11:0]};
            end
        end
        seg_prot = mem_access && (mem_addr_end >= seg_limit);
        for (int i = 0; i < N; i++) begin
            ops[i]   = model_operand(op_sel[i]);
            daddr[i] = 32'h0;
            dtype[i] = 3'b000;
            case (dest_sel[i][3:2])
                mem_pkg::SEL_KIND_REG: {daddr[i], dtype[i]} = {30'h0, dest_sel[i][1:0], 3'b001};
                mem_pkg::SEL_KIND_SEG: {daddr[i], dtype[i]} = {30'h0, dest_sel[i][1:0], 3'b010};
                mem_pkg::SEL_KIND_MEM: {daddr[i], dtype[i]} = {phys, 3'b100};
                default: ;
            endcase
        end
        ie_type = {ie_type_in[3:2], mem_access && !hit, seg_prot || prot};
        checker_i.push_expected(ops, daddr, dtype, ie_in || ie_type[1] || ie_type[0], ie_type);
    endtask

    // one clock edge with the models updated from what the DUT saw
    task automatic step();
        @(posedge clk);
        accepted_now = valid_in && !stall;
        if (accepted_now) push_model();
        if (tlb_wr_en) begin
            m_valid[tlb_wr_idx]    = 1'b1;
            m_vpn[tlb_wr_idx]      = tlb_wr_vpn;
            m_pfn[tlb_wr_idx]      = tlb_wr_pfn;
            m_writable[tlb_wr_idx] = tlb_wr_writable;
        end
        tlb_wr_en <= 1'b0;
        // downstream buffer gives back at most one credit per cycle
        if (valid_out) held++;
        return_pending = returns_on && held > 0 && rand_bits(1) != 0;
        if (return_pending) held--;
        credit_return <= return_pending;
    endtask

    task automatic drain();
        returns_on = 1'b1;
        step();
        while (held != 0 || return_pending || valid_out || accepted_now) step();
    endtask

    task automatic fill_tlb();
        mem_pkg::vpn_t vpn;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            vpn = 20'(rand_bits(20));
            // a repeated page makes the lowest index matter
            if (i > 0 && rand_bits(2) == 0) vpn = page_pool[i - 1];
            page_pool[i] = vpn;
            tlb_wr_en       <= 1'b1;
            tlb_wr_idx      <= IDX_W'(i);
            tlb_wr_vpn      <= vpn;
            tlb_wr_pfn      <= 20'(rand_bits(20));
            tlb_wr_writable <= 1'(rand_bits(1));
            step();
        end
    endtask

    task automatic drive_random(input int mode);
        mem_pkg::addr_t lim;
        mem_pkg::addr_t addr;
        logic [1:0]     pick;
        for (int i = 0; i < N; i++) begin
            reg_data[i] <= rand_bits(32);
            seg_data[i] <= 16'(rand_bits(16));
            op_sel[i]   <= 4'(rand_bits(4));
            dest_sel[i] <= 4'(rand_bits(4));
        end
        mem_data <= rand_bits(32);
        eip      <= rand_bits(32);
        imm      <= {rand_bits(32), rand_bits(32)};
        addr = rand_bits(32);
        if (rand_bits(1) != 0) addr = {page_pool[IDX_W'(rand_bits(IDX_W))], addr[11:0]};
        mem_addr   <= addr;
        mem_write  <= 1'(rand_bits(1));
        mem_access <= (mode == MODE_TLB) ? 1'b1 : 1'(rand_bits(1));
        ie_in      <= 1'(rand_bits(1));
        ie_type_in <= 4'(rand_bits(4));
        lim = rand_bits(32);
        if (mode == MODE_TLB) begin
            // keep segment protection out of the way of TLB faults
            seg_limit    <= 32'hffff_ffff;
            mem_addr_end <= rand_bits(31);
        end else if (mode == MODE_SEG) begin
            pick = 2'(rand_bits(2));
            seg_limit    <= lim;
            mem_addr_end <= (pick == 0) ? lim - 1 : (pick == 1) ? lim :
                            (pick == 2) ? lim + 1 : rand_bits(32);
        end else begin
            seg_limit    <= lim;
            mem_addr_end <= rand_bits(32);
        end
    endtask

    task automatic report(input string name, input int count, input int errs_before);
        $display("test %0d %s: %0d instructions, %0d errors", test_num, name, count,
                 total_errors() - errs_before);
        test_num++;
    endtask

    task automatic run_test(input string name, input int mode, input int count,
                            input logic fill);
        int errs_before;
        int issued;
        errs_before = total_errors();
        issued = 0;
        if (fill) fill_tlb();
        while (issued < count) begin
            if (rand_bits(3) == 0) begin
                valid_in <= 1'b0;
                step();
            end else begin
                drive_random(mode);
                valid_in <= 1'b1;
                step();
                while (!accepted_now) step();
                issued++;
            end
        end
        valid_in <= 1'b0;
        drain();
        report(name, issued, errs_before);
    endtask

    task automatic credit_test();
        int errs_before;
        int taken;
        errs_before = total_errors();
        taken = 0;
        returns_on = 1'b0;
        drive_random(MODE_OPS);
        valid_in <= 1'b1;
        repeat (3 * EX_CREDITS) begin
            step();
            if (accepted_now) begin
                taken++;
                drive_random(MODE_OPS);
            end
        end
        if (taken != EX_CREDITS) begin
            tb_fails++;
            $display("credit test accepted %0d instructions on %0d credits", taken, EX_CREDITS);
        end
        if (!stall) begin
            tb_fails++;
            $display("stall stayed low after every credit was spent");
        end
        valid_in <= 1'b0;
        drain();
        report("credit back-pressure", taken, errs_before);
    endtask

    initial begin
        arst_n          = 1'b0;
        tlb_wr_en       = 1'b0;
        tlb_wr_idx      = '0;
        tlb_wr_vpn      = '0;
        tlb_wr_pfn      = '0;
        tlb_wr_writable = 1'b0;
        mem_data        = '0;
        eip             = '0;
        imm             = '0;
        mem_addr        = '0;
        mem_write       = 1'b0;
        mem_access      = 1'b0;
        valid_in        = 1'b0;
        ie_in           = 1'b0;
        ie_type_in      = '0;
        mem_addr_end    = '0;
        seg_limit       = '0;
        credit_return   = 1'b0;
        for (int i = 0; i < N; i++) begin
            reg_data[i] = '0;
            seg_data[i] = '0;
            op_sel[i]   = '0;
            dest_sel[i] = '0;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_valid[i]   = 1'b0;
            page_pool[i] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        run_test("operand selection", MODE_OPS, 300, 1'b0);
        run_test("destination resolution", MODE_DEST, 200, 1'b1);
        run_test("tlb and exceptions", MODE_TLB, 200, 1'b1);
        run_test("segment limit", MODE_SEG, 200, 1'b0);
        credit_test();
        if (checker_i.expected_q.size() != 0) begin
            tb_fails++;
            $display("%0d accepted instructions never came out", checker_i.expected_q.size());
        end
        $display("summary: %0d tests, %0d beats checked, %0d errors", test_num - 1,
                 checker_i.beat_count, total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- list.f
source/mem_pkg.sv
source/tlb_lookup_if.sv
source/operand_if.sv
source/tlb.sv
source/opswap.sv
source/mem_stage_reg.sv
source/mem_top.sv
bench/mem_stage_assertions.sv
bench/mem_checker.sv
bench/tb_mem_top.sv

//--- source/mem_pkg.sv
package mem_pkg;

    // operand and destination count per instruction
    localparam int NUM_OPS = 4;

    // low address bits kept across translation
    localparam int PAGE_OFFSET_W = 12;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] pfn_t;
    typedef logic [15:0] seg_t;

    // [3:2] kind, [1:0] index
    typedef logic [3:0] sel_t;

    // one-hot, bit 0 reg, bit 1 seg, bit 2 mem
    typedef logic [2:0] dest_type_t;

    // bit 0 protection, bit 1 page fault, upper bits pass through
    typedef logic [3:0] ie_type_t;

    typedef logic [63:0] imm_t;

    // select kind codes
    localparam logic [1:0] SEL_KIND_REG     = 2'd0;
    localparam logic [1:0] SEL_KIND_SEG     = 2'd1;
    localparam logic [1:0] SEL_KIND_MEM     = 2'd2;
    localparam logic [1:0] SEL_KIND_SPECIAL = 2'd3;

    // special indices
    localparam logic [1:0] SPECIAL_EIP    = 2'd0;
    localparam logic [1:0] SPECIAL_IMM_LO = 2'd1;
    localparam logic [1:0] SPECIAL_IMM_HI = 2'd2;
    localparam logic [1:0] SPECIAL_ZERO   = 2'd3;

    // destination type encodings
    localparam dest_type_t DEST_NONE = 3'b000;
    localparam dest_type_t DEST_REG  = 3'b001;
    localparam dest_type_t DEST_SEG  = 3'b010;
    localparam dest_type_t DEST_MEM  = 3'b100;

endpackage

//--- source/mem_stage_reg.sv
`timescale 1ns/1ps

module mem_stage_reg #(
    parameter int EX_CREDITS = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                valid_in,
    input  logic                ie_in,
    input  mem_pkg::ie_type_t   ie_type_in,
    input  logic                mem_access,
    input  mem_pkg::addr_t      mem_addr_end,
    input  mem_pkg::addr_t      seg_limit,
    tlb_lookup_if.observer      lookup,
    operand_if.sink             operands,
    input  logic                credit_return,
    output logic                stall,
    output logic                valid_out,
    output mem_pkg::data_t      op_val    [mem_pkg::NUM_OPS],
    output mem_pkg::addr_t      dest_addr [mem_pkg::NUM_OPS],
    output mem_pkg::dest_type_t dest_type [mem_pkg::NUM_OPS],
    output logic                ie_out,
    output mem_pkg::ie_type_t   ie_type_out
);

    localparam int CNT_W = $clog2(EX_CREDITS + 1);

    logic [CNT_W-1:0]  credit_cnt;
    logic              accept;
    logic              seg_prot;
    logic              tlb_prot;
    logic              tlb_miss;
    logic              ie_next;
    mem_pkg::ie_type_t ie_type_next;

    // new exception bits only for a memory access
    assign seg_prot = mem_access && (mem_addr_end >= seg_limit);
    assign tlb_prot = mem_access && lookup.prot;
    assign tlb_miss = mem_access && !lookup.hit;

    assign ie_type_next = {ie_type_in[3:2], tlb_miss, seg_prot | tlb_prot};
    assign ie_next      = ie_in | seg_prot | tlb_prot | tlb_miss;

    // no credit left means execute has no room
    assign stall  = (credit_cnt == '0);
    assign accept = valid_in && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CNT_W'(EX_CREDITS);
        end else begin
            case ({accept, credit_return})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: begin
                    // a stray return must not push past the buffer depth
                    if (credit_cnt < CNT_W'(EX_CREDITS)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= accept;
        end
    end

    // payload toward execute
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < mem_pkg::NUM_OPS; i++) begin
                op_val[i]    <= operands.ops[i];
                dest_addr[i] <= operands.dest_addr[i];
                dest_type[i] <= operands.dest_type[i];
            end
            ie_out      <= ie_next;
            ie_type_out <= ie_type_next;
        end
    end

endmodule

//--- source/mem_top.sv
`timescale 1ns/1ps

module mem_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int EX_CREDITS  = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           tlb_wr_en,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_wr_idx,
    input  mem_pkg::vpn_t                  tlb_wr_vpn,
    input  mem_pkg::pfn_t                  tlb_wr_pfn,
    input  logic                           tlb_wr_writable,
    input  mem_pkg::data_t                 reg_data [mem_pkg::NUM_OPS],
    input  mem_pkg::seg_t                  seg_data [mem_pkg::NUM_OPS],
    input  mem_pkg::data_t                 mem_data,
    input  mem_pkg::addr_t                 eip,
    input  mem_pkg::imm_t                  imm,
    input  mem_pkg::addr_t                 mem_addr,
    input  logic                           mem_write,
    input  logic                           mem_access,
    input  mem_pkg::sel_t                  op_sel   [mem_pkg::NUM_OPS],
    input  mem_pkg::sel_t                  dest_sel [mem_pkg::NUM_OPS],
    input  logic                           valid_in,
    input  logic                           ie_in,
    input  mem_pkg::ie_type_t              ie_type_in,
    input  mem_pkg::addr_t                 mem_addr_end,
    input  mem_pkg::addr_t                 seg_limit,
    input  logic                           credit_return,
    output logic                           stall,
    output logic                           valid_out,
    output mem_pkg::data_t                 op_val    [mem_pkg::NUM_OPS],
    output mem_pkg::addr_t                 dest_addr [mem_pkg::NUM_OPS],
    output mem_pkg::dest_type_t            dest_type [mem_pkg::NUM_OPS],
    output logic                           ie_out,
    output mem_pkg::ie_type_t              ie_type_out
);

    tlb_lookup_if lookup_bus ();
    operand_if    operand_bus ();

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_i (
        .clk(clk), .arst_n(arst_n),
        .tlb_wr_en(tlb_wr_en), .tlb_wr_idx(tlb_wr_idx),
        .tlb_wr_vpn(tlb_wr_vpn), .tlb_wr_pfn(tlb_wr_pfn),
        .tlb_wr_writable(tlb_wr_writable),
        .lookup(lookup_bus.responder)
    );

    opswap opswap_i (
        .reg_data(reg_data), .seg_data(seg_data), .mem_data(mem_data),
        .eip(eip), .imm(imm),
        .mem_addr(mem_addr), .mem_write(mem_write), .mem_access(mem_access),
        .op_sel(op_sel), .dest_sel(dest_sel),
        .lookup(lookup_bus.requester), .operands(operand_bus.source)
    );

    mem_stage_reg #(.EX_CREDITS(EX_CREDITS)) stage_i (
        .clk(clk), .arst_n(arst_n),
        .valid_in(valid_in), .ie_in(ie_in), .ie_type_in(ie_type_in),
        .mem_access(mem_access), .mem_addr_end(mem_addr_end), .seg_limit(seg_limit),
        .lookup(lookup_bus.observer), .operands(operand_bus.sink),
        .credit_return(credit_return), .stall(stall), .valid_out(valid_out),
        .op_val(op_val), .dest_addr(dest_addr), .dest_type(dest_type),
        .ie_out(ie_out), .ie_type_out(ie_type_out)
    );

endmodule

//--- source/operand_if.sv
`timescale 1ns/1ps

interface operand_if;

    // resolved operand values
    mem_pkg::data_t      ops       [mem_pkg::NUM_OPS];

    // resolved destinations
    mem_pkg::addr_t      dest_addr [mem_pkg::NUM_OPS];
    mem_pkg::dest_type_t dest_type [mem_pkg::NUM_OPS];

    modport source (
        output ops,
        output dest_addr,
        output dest_type
    );

    modport sink (
        input ops,
        input dest_addr,
        input dest_type
    );

endinterface

//--- source/opswap.sv
`timescale 1ns/1ps

module opswap (
    input  mem_pkg::data_t  reg_data [mem_pkg::NUM_OPS],
    input  mem_pkg::seg_t   seg_data [mem_pkg::NUM_OPS],
    input  mem_pkg::data_t  mem_data,
    input  mem_pkg::addr_t  eip,
    input  mem_pkg::imm_t   imm,
    input  mem_pkg::addr_t  mem_addr,
    input  logic            mem_write,
    input  logic            mem_access,
    input  mem_pkg::sel_t   op_sel   [mem_pkg::NUM_OPS],
    input  mem_pkg::sel_t   dest_sel [mem_pkg::NUM_OPS],
    tlb_lookup_if.requester lookup,
    operand_if.source       operands
);

    mem_pkg::addr_t phys_addr;

    // lookup only live for a memory access
    assign lookup.lookup_valid = mem_access;
    assign lookup.vaddr        = mem_addr;
    assign lookup.is_write     = mem_write;

    // a miss falls back to the linear address
    assign phys_addr = lookup.hit
                     ? {lookup.pfn, mem_addr[mem_pkg::PAGE_OFFSET_W-1:0]}
                     : mem_addr;

    for (genvar g = 0; g < mem_pkg::NUM_OPS; g++) begin : g_slot
        logic [1:0] op_kind;
        logic [1:0] op_idx;
        logic [1:0] dst_kind;
        logic [1:0] dst_idx;

        assign op_kind  = op_sel[g][3:2];
        assign op_idx   = op_sel[g][1:0];
        assign dst_kind = dest_sel[g][3:2];
        assign dst_idx  = dest_sel[g][1:0];

        // operand value
        always_comb begin
            case (op_kind)
                mem_pkg::SEL_KIND_REG: operands.ops[g] = reg_data[op_idx];
                mem_pkg::SEL_KIND_SEG: operands.ops[g] = mem_pkg::data_t'(seg_data[op_idx]);
                mem_pkg::SEL_KIND_MEM: operands.ops[g] = mem_data;
                default: begin
                    case (op_idx)
                        mem_pkg::SPECIAL_EIP:    operands.ops[g] = eip;
                        mem_pkg::SPECIAL_IMM_LO: operands.ops[g] = imm[31:0];
                        mem_pkg::SPECIAL_IMM_HI: operands.ops[g] = imm[63:32];
                        default:                 operands.ops[g] = '0;
                    endcase
                end
            endcase
        end

        // destination address and type
        always_comb begin
            case (dst_kind)
                mem_pkg::SEL_KIND_REG: begin
                    operands.dest_addr[g] = mem_pkg::addr_t'(dst_idx);
                    operands.dest_type[g] = mem_pkg::DEST_REG;
                end
                mem_pkg::SEL_KIND_SEG: begin
                    operands.dest_addr[g] = mem_pkg::addr_t'(dst_idx);
                    operands.dest_type[g] = mem_pkg::DEST_SEG;
                end
                mem_pkg::SEL_KIND_MEM: begin
                    operands.dest_addr[g] = phys_addr;
                    operands.dest_type[g] = mem_pkg::DEST_MEM;
                end
                default: begin
                    // special kinds write nothing
                    operands.dest_addr[g] = '0;
                    operands.dest_type[g] = mem_pkg::DEST_NONE;
                end
            endcase
        end
    end

endmodule

//--- source/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            tlb_wr_en,
    input  logic [$clog2(TLB_ENTRIES)-1:0]  tlb_wr_idx,
    input  mem_pkg::vpn_t                   tlb_wr_vpn,
    input  mem_pkg::pfn_t                   tlb_wr_pfn,
    input  logic                            tlb_wr_writable,
    tlb_lookup_if.responder                 lookup
);

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TLB_ENTRIES-1:0] entry_writable;
    mem_pkg::vpn_t          entry_vpn [TLB_ENTRIES];
    mem_pkg::pfn_t          entry_pfn [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] match;
    mem_pkg::vpn_t          lookup_vpn;

    assign lookup_vpn = lookup.vaddr[31:mem_pkg::PAGE_OFFSET_W];

    // entry valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else if (tlb_wr_en) begin
            entry_valid[tlb_wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr_en) begin
            entry_vpn[tlb_wr_idx]      <= tlb_wr_vpn;
            entry_pfn[tlb_wr_idx]      <= tlb_wr_pfn;
            entry_writable[tlb_wr_idx] <= tlb_wr_writable;
        end
    end

    // compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = entry_valid[i] && (entry_vpn[i] == lookup_vpn);
        end
    end

    // walk from the top down so the lowest matching index is the one left standing
    always_comb begin
        lookup.hit  = 1'b0;
        lookup.prot = 1'b0;
        lookup.pfn  = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (lookup.lookup_valid && match[i]) begin
                lookup.hit  = 1'b1;
                lookup.pfn  = entry_pfn[i];
                // write to a read-only page
                lookup.prot = lookup.is_write && !entry_writable[i];
            end
        end
    end

endmodule

//--- source/tlb_lookup_if.sv
`timescale 1ns/1ps

interface tlb_lookup_if;

    // request side
    logic            lookup_valid;
    mem_pkg::addr_t  vaddr;
    logic            is_write;

    // prot only meaningful with hit
    logic            hit;
    logic            prot;
    mem_pkg::pfn_t   pfn;

    modport requester (output lookup_valid, output vaddr, output is_write,
                       input hit, input prot, input pfn);

    modport responder (input lookup_valid, input vaddr, input is_write,
                       output hit, output prot, output pfn);

    // exception merge only needs the result flags
    modport observer (input hit, input prot);

endinterface
